/* sources.f */
source/emesh_pkg.sv
source/mmu_pkg.sv
source/mmu_table.sv
source/emmu.sv
source/emmu_top.sv
testbench/emmu_checker.sv
testbench/emmu_tb.sv

/* Makefile */
# Verilator run of the address translation testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module emmu_tb -Mdir obj_dir
	./obj_dir/Vemmu_tb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/emmu_tb.sv */
// testbench for the translation top level
//  clock, reset, stimulus table applied in a loop
//  model table updated with every lane write
//  wait hold and back-to-back sequences, error counts

`timescale 1ns/1ps
`default_nettype none

module emmu_tb;

   localparam int n_rows   = 10;
   localparam int max_wait = 20;   // cycles before giving up on access_out

   typedef logic [8*10-1:0] name_t;   // ten character test names
   typedef logic [127:0]    wide_t;   // common width for compares

   typedef struct packed {
      name_t            name;
      logic             en;
      logic             bp;
      emesh_pkg::addr_t dst;
      logic [1:0]       lanes;    // bit0 low lane and bit1 high lane
      logic [31:0]      lo_val;
      logic [31:0]      hi_val;   // only 15:0 lands in the entry
      logic             hold;     // wait_in pulse after the output
   } row_t;

   logic                clk;
   logic                reset;
   logic                mmu_en;
   logic                mmu_bp;
   logic                cfg_en;
   logic                cfg_we;
   mmu_pkg::cfg_addr_t  cfg_addr;
   mmu_pkg::cfg_data_t  cfg_data;
   logic                access_in;
   emesh_pkg::packet_t  packet_in;
   logic                wait_in;
   logic                access_out;
   emesh_pkg::packet_t  packet_out;
   emesh_pkg::addr_t    addr_hi;

   row_t            rows [0:n_rows-1];
   mmu_pkg::entry_t model_tbl [0:4095];   // mirrors every table write
   int              checks = 0;
   int              errors = 0;
   int              timeouts = 0;

   emmu_top u_dut (
      .clk        (clk),
      .reset      (reset),
      .mmu_en     (mmu_en),
      .mmu_bp     (mmu_bp),
      .cfg_en     (cfg_en),
      .cfg_we     (cfg_we),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .addr_hi    (addr_hi)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   task automatic check_value(input name_t name, input string what,
                              input wide_t exp, input wide_t act);
      checks++;
      assert (act === exp) else begin
         $display("Mismatch %s %s expected %h actual %h", name, what, exp, act);
         errors++;
      end
   endtask

   // one lane write with the model updated alongside
   task automatic write_lane(input logic [11:0] idx, input logic hi,
                             input mmu_pkg::cfg_data_t val);
      mmu_pkg::entry_t ent;
      @(negedge clk);
      cfg_en   = 1'b1;
      cfg_we   = 1'b1;
      cfg_addr = {idx, hi, 2'b00};   // bit 2 picks the lane
      cfg_data = val;
      @(negedge clk);
      cfg_en = 1'b0;
      cfg_we = 1'b0;
      ent = model_tbl[idx];
      if (hi) begin
         ent[47:32] = val[15:0];
      end else begin
         ent[31:0] = val;
      end
      model_tbl[idx] = ent;
   endtask

   // translation rule on the model table
   function automatic mmu_pkg::addr64_t expect_addr(input logic en, input logic bp,
                                                     input emesh_pkg::addr_t dst);
      mmu_pkg::entry_t ent;
      ent = model_tbl[dst[31:20]];
      if (en && !bp) begin
         return {ent[43:0], dst[19:0]};   // page replaced and offset kept
      end else begin
         return {32'h0, dst};
      end
   endfunction

   function automatic emesh_pkg::packet_t make_packet(input emesh_pkg::addr_t dst);
      logic [31:0] r_ctrl;
      logic [31:0] r_data;
      logic [31:0] r_src;
      r_ctrl = $urandom();
      r_data = $urandom();
      r_src  = $urandom();
      return {r_src, r_data, dst, r_ctrl[7:0]};
   endfunction

   task automatic check_output(input name_t name, input emesh_pkg::packet_t pkt,
                               input mmu_pkg::addr64_t a64);
      emesh_pkg::packet_t want;
      want = pkt;
      want[emesh_pkg::dst_msb:emesh_pkg::dst_lsb] = a64[31:0];
      check_value(name, "packet_out", wide_t'(want), wide_t'(packet_out));
      check_value(name, "addr_hi", wide_t'(a64[63:32]), wide_t'(addr_hi));
   endtask

   // polls at falling edges and counts extra cycles in lat
   task automatic wait_access(input name_t name, output int lat);
      lat = 0;
      while (access_out !== 1'b1 && lat < max_wait) begin
         @(negedge clk);
         lat++;
      end
      if (access_out !== 1'b1) begin
         $display("Error: %s access_out did not rise within %0d cycles", name, max_wait);
         timeouts++;
      end
   endtask

   task automatic run_row(input row_t r);
      emesh_pkg::packet_t pkt;
      mmu_pkg::addr64_t   a64;
      int                 lat;
      @(negedge clk);
      mmu_en = r.en;
      mmu_bp = r.bp;
      if (r.lanes[0]) begin
         write_lane(r.dst[31:20], 1'b0, r.lo_val);
      end
      if (r.lanes[1]) begin
         write_lane(r.dst[31:20], 1'b1, r.hi_val);
      end
      pkt = make_packet(r.dst);
      a64 = expect_addr(r.en, r.bp, r.dst);
      @(negedge clk);
      access_in = 1'b1;
      packet_in = pkt;
      @(negedge clk);
      access_in = 1'b0;   // taken at the edge just passed
      wait_access(r.name, lat);
      if (access_out === 1'b1) begin
         check_value(r.name, "latency", wide_t'(0), wide_t'(lat));
         check_output(r.name, pkt, a64);
         if (r.hold) begin
            wait_in = 1'b1;
            repeat (4) begin
               @(negedge clk);
               check_value(r.name, "access_out", wide_t'(1), wide_t'(access_out));
               check_output(r.name, pkt, a64);   // frozen copy
            end
            wait_in = 1'b0;
         end
      end
      @(negedge clk);
      check_value(r.name, "access_out", wide_t'(0), wide_t'(access_out));   // no repeat
   endtask

   // four packets on consecutive cycles with outputs one cycle behind
   task automatic run_back_to_back();
      emesh_pkg::addr_t   dsts [0:3];
      emesh_pkg::packet_t pkts [0:3];
      mmu_pkg::addr64_t   a64s [0:3];
      dsts = '{32'h1230_0010, 32'hfff0_0020, 32'h0000_0030, 32'h1231_0040};
      @(negedge clk);
      mmu_en = 1'b1;
      mmu_bp = 1'b0;
      for (int k = 0; k <= 4; k++) begin
         @(negedge clk);
         if (k > 0) begin
            check_value("b2b_stream", "access_out", wide_t'(1), wide_t'(access_out));
            check_output("b2b_stream", pkts[k-1], a64s[k-1]);
         end
         if (k < 4) begin
            pkts[k]   = make_packet(dsts[k]);
            a64s[k]   = expect_addr(1'b1, 1'b0, dsts[k]);
            access_in = 1'b1;
            packet_in = pkts[k];
         end else begin
            access_in = 1'b0;
         end
      end
      @(negedge clk);
      check_value("b2b_stream", "access_out", wide_t'(0), wide_t'(access_out));
   endtask

   initial begin
      void'($urandom(32'h8d20_2576));
      reset     = 1'b1;
      mmu_en    = 1'b0;
      mmu_bp    = 1'b0;
      cfg_en    = 1'b0;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_data  = '0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;

      //          name          en    bp    dst            lanes  lo_val         hi_val
      rows[0] = '{"xlate_pg_a", 1'b1, 1'b0, 32'h1234_5678, 2'b11, 32'hcafe_0123, 32'hffff_8a5c,
                  1'b0};
      rows[1] = '{"xlate_pg_b", 1'b1, 1'b0, 32'hfff0_0abc, 2'b11, 32'h0000_0001, 32'h1234_fedc,
                  1'b0};
      rows[2] = '{"xlate_pg_c", 1'b1, 1'b0, 32'h0008_9abc, 2'b11, 32'h8000_0000, 32'hdead_0f0f,
                  1'b0};
      rows[3] = '{"bypass_hit", 1'b1, 1'b1, 32'h1230_0001, 2'b00, 32'h0, 32'h0, 1'b0};
      rows[4] = '{"mmu_en_off", 1'b0, 1'b0, 32'hfff4_4444, 2'b00, 32'h0, 32'h0, 1'b0};
      rows[5] = '{"bypass_new", 1'b1, 1'b1, 32'h7770_1234, 2'b00, 32'h0, 32'h0, 1'b0};
      rows[6] = '{"lane_low32", 1'b1, 1'b0, 32'h123f_ffff, 2'b01, 32'h5555_aaaa, 32'h0, 1'b0};
      rows[7] = '{"lane_hi_16", 1'b1, 1'b0, 32'h1230_0000, 2'b10, 32'h0, 32'hbeef_0707, 1'b0};
      rows[8] = '{"wait_hold1", 1'b1, 1'b0, 32'hfff1_2345, 2'b00, 32'h0, 32'h0, 1'b1};
      rows[9] = '{"wait_hold2", 1'b0, 1'b1, 32'h0001_1111, 2'b00, 32'h0, 32'h0, 1'b1};

      repeat (8) begin
         @(negedge clk);
         check_value("reset_hold", "access_out", wide_t'(0), wide_t'(access_out));
      end
      reset = 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_value("reset_hold", "access_out", wide_t'(0), wide_t'(access_out));
      end

      for (int i = 0; i < n_rows; i++) begin
         run_row(rows[i]);
      end
      run_back_to_back();

      errors += u_dut.u_checker.fail_count;   // bound assertion failures
      $display("checks %0d  errors %0d  timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

bind emmu_top emmu_checker u_checker (
   .clk        (clk),
   .reset      (reset),
   .wait_in    (wait_in),
   .access_out (access_out),
   .packet_out (packet_out),
   .addr_hi    (addr_hi)
);

`default_nettype wire

/* testbench/emmu_checker.sv */
// concurrent checks on the translation top level
//  access_out low while reset is high
//  outputs frozen while wait_in is high
//  no unknown packet bits on a valid output

`timescale 1ns/1ps
`default_nettype none

module emmu_checker (
   input wire                     clk,
   input wire                     reset,
   input wire                     wait_in,
   input wire                     access_out,
   input wire emesh_pkg::packet_t packet_out,
   input wire emesh_pkg::addr_t   addr_hi
);

   int fail_count = 0;   // summed into the testbench error total

   a_reset_low: assert property (@(posedge clk) reset |-> !access_out)
      else begin
         $error("access_out high during reset");
         fail_count++;
      end

   // stalled cycle, next cycle shows the same outputs
   a_wait_hold: assert property (@(posedge clk) disable iff (reset)
      wait_in |=> ($stable(access_out) && $stable(packet_out) && $stable(addr_hi)))
      else begin
         $error("outputs changed while wait_in was high");
         fail_count++;
      end

   a_no_x: assert property (@(posedge clk) disable iff (reset)
      access_out |-> !$isunknown(packet_out))
      else begin
         $error("packet_out has unknown bits while access_out is high");
         fail_count++;
      end

endmodule

`default_nettype wire

/* source/emmu_top.sv */
// translation top level
//  table instance fed by the configuration port
//  translation stage instance fed by the packet input
//  table_aw passed to both

`timescale 1ns/1ps
`default_nettype none

module emmu_top #(
   parameter int table_aw = 12
) (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      mmu_en,
   input  wire                      mmu_bp,
   input  wire                      cfg_en,
   input  wire                      cfg_we,
   input  wire mmu_pkg::cfg_addr_t  cfg_addr,
   input  wire mmu_pkg::cfg_data_t  cfg_data,
   input  wire                      access_in,
   input  wire emesh_pkg::packet_t  packet_in,
   input  wire                      wait_in,
   output logic                     access_out,
   output emesh_pkg::packet_t       packet_out,
   output emesh_pkg::addr_t         addr_hi
);

   logic                rd_en;          // lookup enable, stage to table
   logic [table_aw-1:0] rd_index;
   mmu_pkg::entry_t     lookup_data;    // one cycle after rd_en

   mmu_table #(.table_aw(table_aw)) u_table (
      .clk         (clk),
      .reset       (reset),
      .cfg_en      (cfg_en),
      .cfg_we      (cfg_we),
      .cfg_addr    (cfg_addr),
      .cfg_data    (cfg_data),
      .rd_en       (rd_en),
      .rd_index    (rd_index),
      .lookup_data (lookup_data)
   );

   emmu #(.table_aw(table_aw)) u_emmu (
      .clk         (clk),
      .reset       (reset),
      .mmu_en      (mmu_en),
      .mmu_bp      (mmu_bp),
      .access_in   (access_in),
      .packet_in   (packet_in),
      .wait_in     (wait_in),
      .lookup_data (lookup_data),
      .rd_en       (rd_en),
      .rd_index    (rd_index),
      .access_out  (access_out),
      .packet_out  (packet_out),
      .addr_hi     (addr_hi)
   );

endmodule

`default_nettype wire

/* source/emmu.sv */
// address translation stage
//  lookup index and read enable toward the table
//  one packet pipeline register aligned with the table read
//  64-bit address substitution, output packet assembly

`timescale 1ns/1ps
`default_nettype none

module emmu #(
   parameter int table_aw = 12
) (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     mmu_en,       // translation on (static)
   input  wire                     mmu_bp,       // bypass, passes address as is
   input  wire                     access_in,
   input  wire emesh_pkg::packet_t packet_in,
   input  wire                     wait_in,      // downstream pushback
   input  wire mmu_pkg::entry_t    lookup_data,
   output logic                    rd_en,
   output logic [table_aw-1:0]     rd_index,
   output logic                    access_out,
   output emesh_pkg::packet_t      packet_out,
   output emesh_pkg::addr_t        addr_hi
);

   // table index sits right above the kept page offset
   localparam int idx_pos = emesh_pkg::dst_lsb + emesh_pkg::page_lsb;

   emesh_pkg::packet_t packet_reg;
   mmu_pkg::addr64_t   dst64;
   logic               xlate;

   // packet accepted only when not stalled
   assign rd_en = access_in & ~wait_in;

   // fewer index bits just alias the upper pages
   assign rd_index = packet_in[idx_pos +: table_aw] & {table_aw{rd_en}};

   // access pipeline, held under wait
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         access_out <= 1'b0;
      end else if (!wait_in) begin
         access_out <= access_in;
      end
   end

   // packet payload, same cycle as the table read
   always_ff @(posedge clk) begin
      if (rd_en) begin
         packet_reg <= packet_in;
      end
   end

   assign xlate = mmu_en & ~mmu_bp;

   // entry bits replace dst 31:20, widening to 64 bits
   always_comb begin
      if (xlate) begin
         dst64 = {lookup_data[mmu_pkg::xlate_w-1:0],
                  packet_reg[emesh_pkg::dst_lsb +: emesh_pkg::page_lsb]};
      end else begin
         dst64 = {32'b0, packet_reg[emesh_pkg::dst_msb:emesh_pkg::dst_lsb]};   // untouched
      end
   end

   // low half back into the dst field, rest of packet unchanged
   assign packet_out = {packet_reg[emesh_pkg::pw-1:emesh_pkg::dst_msb+1],
                        dst64[emesh_pkg::aw-1:0],
                        packet_reg[emesh_pkg::dst_lsb-1:0]};

   assign addr_hi = dst64[63:emesh_pkg::aw];   // zero in bypass

endmodule

`default_nettype wire

/* source/mmu_table.sv */
// translation table
//  byte lane write from the configuration port
//  low/high lane select from configuration address bit 2
//  registered lookup read, held while read enable is low

`timescale 1ns/1ps
`default_nettype none

module mmu_table #(
   parameter int table_aw = 12          // entries = 2**table_aw
) (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    cfg_en,
   input  wire                    cfg_we,
   input  wire mmu_pkg::cfg_addr_t cfg_addr,
   input  wire mmu_pkg::cfg_data_t cfg_data,
   input  wire                    rd_en,
   input  wire [table_aw-1:0]     rd_index,
   output mmu_pkg::entry_t        lookup_data
);

   localparam int depth = 1 << table_aw;

   mmu_pkg::entry_t mem [0:depth-1];     // no init, undefined until written
   mmu_pkg::lane_t  wr_vec;              // byte enables for this cycle
   mmu_pkg::entry_t wr_data;
   logic [table_aw-1:0] wr_idx;

   // upper cfg index bits dropped when the table is smaller
   assign wr_idx = cfg_addr[mmu_pkg::idx_lsb +: table_aw];

   // same word on both halves, lane enables pick the half
   assign wr_data = {cfg_data[mmu_pkg::entry_w-mmu_pkg::cfg_dw-1:0], cfg_data};

   // lane decode, config writes ignored during reset
   always_comb begin
      wr_vec = '0;
      if (cfg_en && cfg_we && !reset) begin
         if (cfg_addr[mmu_pkg::lane_bit]) begin
            wr_vec = mmu_pkg::lane_hi;   // only low 16 data bits land
         end else begin
            wr_vec = mmu_pkg::lane_lo;
         end
      end
   end

   // byte wise write
   always_ff @(posedge clk) begin
      for (int b = 0; b < mmu_pkg::lane_w; b++) begin
         if (wr_vec[b]) begin
            mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
         end
      end
   end

   // lookup port, frozen when rd_en low (stall or idle)
   always_ff @(posedge clk) begin
      if (rd_en) begin
         lookup_data <= mem[rd_index];
      end
   end

endmodule

`default_nettype wire

/* source/mmu_pkg.sv */
// translation table definitions
//  entry width and the part of it used for translation
//  configuration address and data types
//  byte lane write vector and the two lane patterns
//  64-bit translated address type

`default_nettype none

package mmu_pkg;

   localparam int entry_w = 48;              // stored bits per entry
   localparam int xlate_w = 44;              // entry bits used in the address
   localparam int lane_w  = entry_w / 8;     // one enable per byte
   localparam int cfg_aw  = 15;
   localparam int cfg_dw  = 32;
   localparam int lane_bit = 2;              // picks low or high half of an entry
   localparam int idx_lsb  = 3;              // entry index starts here in cfg_addr

   typedef logic [entry_w-1:0] entry_t;
   typedef logic [cfg_aw-1:0]  cfg_addr_t;
   typedef logic [cfg_dw-1:0]  cfg_data_t;
   typedef logic [lane_w-1:0]  lane_t;
   typedef logic [63:0]        addr64_t;

   localparam lane_t lane_lo = 6'b00_1111;   // entry bits 31:0
   localparam lane_t lane_hi = 6'b11_0000;   // entry bits 47:32

endpackage

`default_nettype wire

/* source/emesh_pkg.sv */
// mesh packet definitions
//  packet width and the packet vector type
//  destination field position in the packet
//  page offset boundary kept through translation
//  plain 32-bit address type

`default_nettype none

package emesh_pkg;

   localparam int pw = 104;   // full packet width
   localparam int aw = 32;    // mesh address width

   // packet layout, lsb first
   //   ctrl    7:0
   //   dst     39:8
   //   data    71:40
   //   src     103:72
   localparam int dst_lsb = 8;
   localparam int dst_msb = dst_lsb + aw - 1;   // 39

   // low dst bits that survive translation untouched
   localparam int page_lsb = 20;

   typedef logic [pw-1:0] packet_t;   // whole packet as one vector
   typedef logic [aw-1:0] addr_t;     // one mesh address

endpackage

`default_nettype wire
